// File: design/rvs_pkg.sv
`default_nettype none

package rvs_pkg;

  // Data path widths
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;

  // Major opcodes of the supported subset
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_IMM
  } alu_op_e;

  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_FETCH,
    CTRL_EXECUTE,
    CTRL_MEMORY,
    CTRL_HALTED
  } ctrl_state_e;

  typedef struct packed {
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    alu_op_e  alu_op;
    word_t    imm;
    logic     reg_write;
    logic     load;
    logic     store;
    logic     branch;
    logic     branch_ne;  // set for BNE, clear for BEQ
    logic     jump;
    logic     use_imm;
    logic     illegal;
  } decoded_t;

endpackage

`default_nettype wire

// File: design/rvs_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Controller to fetch unit
interface fetch_if;
  import rvs_pkg::*;

  logic   req;
  addr_t  addr;
  logic   valid;
  instr_t instr;
  logic   err;

  modport master (output req, output addr, input valid, input instr, input err);
  modport slave  (input req, input addr, output valid, output instr, output err);
endinterface

// Controller to load/store unit
interface lsu_if;
  import rvs_pkg::*;

  logic  req;
  logic  we;
  addr_t addr;
  word_t wdata;
  logic  done;
  word_t rdata;
  logic  err;

  modport master (
    output req, output we, output addr, output wdata,
    input  done, input rdata, input err
  );
  modport slave (
    input  req, input we, input addr, input wdata,
    output done, output rdata, output err
  );
endinterface

`default_nettype wire

// File: design/rvs_fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rvs_fetch_unit (
  input  logic            clk_i,
  input  logic            rst_i,
  fetch_if.slave          fetch,
  output logic            instr_req_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  output rvs_pkg::addr_t  instr_addr_o,
  input  rvs_pkg::instr_t instr_rdata_i,
  input  logic            instr_err_i
);
  import rvs_pkg::*;

  typedef enum logic {
    FU_GNT,
    FU_RVALID
  } fu_state_e;

  fu_state_e state_q;
  logic      pend_q;
  addr_t     addr_q;

  // Request goes out on the pulse itself, then is held until granted
  assign instr_req_o  = (state_q == FU_GNT) && (fetch.req || pend_q);
  assign instr_addr_o = pend_q ? addr_q : fetch.addr;

  // Response phase
  assign fetch.valid = (state_q == FU_RVALID) && instr_rvalid_i;
  assign fetch.instr = instr_rdata_i;
  assign fetch.err   = instr_err_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= FU_GNT;
      pend_q  <= 1'b0;
    end else begin
      case (state_q)
        FU_GNT: begin
          if (instr_req_o && instr_gnt_i) begin
            state_q <= FU_RVALID;
            pend_q  <= 1'b0;
          end else if (instr_req_o) begin
            pend_q <= 1'b1;
          end
        end
        default: begin
          if (instr_rvalid_i) begin
            state_q <= FU_GNT;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch.req) begin
      addr_q <= fetch.addr;
    end
  end

endmodule

`default_nettype wire

// File: design/rvs_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rvs_decoder #(
  parameter int RF_NUM_REGS = 32
) (
  input  rvs_pkg::instr_t   instr_i,
  output rvs_pkg::decoded_t dec_o
);
  import rvs_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;
  logic       use_rs1;
  logic       use_rs2;
  logic       bad_enc;
  logic       bad_reg;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign rd     = instr_i[11:7];

  // Sign-extended immediates per format
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};

  always_comb begin
    dec_o           = '0;
    dec_o.rs1       = rs1;
    dec_o.rs2       = rs2;
    dec_o.rd        = rd;
    dec_o.alu_op    = ALU_ADD;
    dec_o.imm       = imm_i;
    use_rs1         = 1'b0;
    use_rs2         = 1'b0;
    bad_enc         = 1'b0;
    case (opcode)
      OPC_LUI: begin
        dec_o.alu_op    = ALU_PASS_IMM;
        dec_o.imm       = imm_u;
        dec_o.use_imm   = 1'b1;
        dec_o.reg_write = 1'b1;
      end
      OPC_OPIMM: begin
        // ADDI only
        bad_enc         = (funct3 != 3'b000);
        dec_o.use_imm   = 1'b1;
        dec_o.reg_write = 1'b1;
        use_rs1         = 1'b1;
      end
      OPC_OP: begin
        dec_o.reg_write = 1'b1;
        use_rs1         = 1'b1;
        use_rs2         = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: dec_o.alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: dec_o.alu_op = ALU_SUB;
          {7'b0000000, 3'b100}: dec_o.alu_op = ALU_XOR;
          {7'b0000000, 3'b110}: dec_o.alu_op = ALU_OR;
          {7'b0000000, 3'b111}: dec_o.alu_op = ALU_AND;
          default:              bad_enc      = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        bad_enc         = (funct3 != 3'b010);
        dec_o.load      = 1'b1;
        dec_o.use_imm   = 1'b1;
        dec_o.reg_write = 1'b1;
        use_rs1         = 1'b1;
      end
      OPC_STORE: begin
        bad_enc       = (funct3 != 3'b010);
        dec_o.store   = 1'b1;
        dec_o.imm     = imm_s;
        dec_o.use_imm = 1'b1;
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
      end
      OPC_BRANCH: begin
        bad_enc         = (funct3[2:1] != 2'b00);
        dec_o.branch    = 1'b1;
        dec_o.branch_ne = funct3[0];
        dec_o.imm       = imm_b;
        use_rs1         = 1'b1;
        use_rs2         = 1'b1;
      end
      OPC_JAL: begin
        dec_o.jump      = 1'b1;
        dec_o.imm       = imm_j;
        dec_o.reg_write = 1'b1;
      end
      default: begin
        bad_enc = 1'b1;
      end
    endcase
    // Only registers the instruction actually touches are range-checked
    bad_reg = (use_rs1 && int'(rs1) >= RF_NUM_REGS) ||
              (use_rs2 && int'(rs2) >= RF_NUM_REGS) ||
              (dec_o.reg_write && int'(rd) >= RF_NUM_REGS);
    dec_o.illegal = bad_enc || bad_reg;
  end

endmodule

`default_nettype wire

// File: design/rvs_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rvs_regfile #(
  parameter int RF_NUM_REGS = 32
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  rvs_pkg::reg_idx_t raddr_a_i,
  input  rvs_pkg::reg_idx_t raddr_b_i,
  output rvs_pkg::word_t    rdata_a_o,
  output rvs_pkg::word_t    rdata_b_o,
  input  logic              we_i,
  input  rvs_pkg::reg_idx_t waddr_i,
  input  rvs_pkg::word_t    wdata_i
);
  import rvs_pkg::*;

  word_t regs_q [RF_NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < RF_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0) && (int'(waddr_i) < RF_NUM_REGS)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // x0 and unimplemented indices read as zero
  assign rdata_a_o = ((raddr_a_i == '0) || (int'(raddr_a_i) >= RF_NUM_REGS)) ?
                     '0 : regs_q[raddr_a_i];
  assign rdata_b_o = ((raddr_b_i == '0) || (int'(raddr_b_i) >= RF_NUM_REGS)) ?
                     '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// File: design/rvs_controller.sv
`timescale 1ns/1ps
`default_nettype none

module rvs_controller (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              fetch_enable_i,
  input  rvs_pkg::addr_t    boot_addr_i,
  fetch_if.master           fetch,
  lsu_if.master             lsu,
  output rvs_pkg::instr_t   instr_o,
  input  rvs_pkg::decoded_t dec_i,
  output rvs_pkg::reg_idx_t rf_raddr_a_o,
  output rvs_pkg::reg_idx_t rf_raddr_b_o,
  input  rvs_pkg::word_t    rf_rdata_a_i,
  input  rvs_pkg::word_t    rf_rdata_b_i,
  output logic              rf_we_o,
  output rvs_pkg::reg_idx_t rf_waddr_o,
  output rvs_pkg::word_t    rf_wdata_o,
  output logic              halted_o
);
  import rvs_pkg::*;

  ctrl_state_e state_q;
  addr_t       pc_q;
  instr_t      instr_q;
  logic        fetch_req_q;
  word_t       op_b;
  word_t       alu_result;
  logic        branch_taken;
  addr_t       pc_plus4;
  addr_t       pc_target;
  logic        exec_ok;
  logic        mem_op;

  assign instr_o      = instr_q;
  assign rf_raddr_a_o = dec_i.rs1;
  assign rf_raddr_b_o = dec_i.rs2;

  // ALU, also forms the load/store address
  assign op_b = dec_i.use_imm ? dec_i.imm : rf_rdata_b_i;

  always_comb begin
    case (dec_i.alu_op)
      ALU_ADD: alu_result = rf_rdata_a_i + op_b;
      ALU_SUB: alu_result = rf_rdata_a_i - op_b;
      ALU_AND: alu_result = rf_rdata_a_i & op_b;
      ALU_OR:  alu_result = rf_rdata_a_i | op_b;
      ALU_XOR: alu_result = rf_rdata_a_i ^ op_b;
      default: alu_result = dec_i.imm;
    endcase
  end

  assign branch_taken = dec_i.branch &&
                        ((rf_rdata_a_i == rf_rdata_b_i) != dec_i.branch_ne);
  assign pc_plus4     = pc_q + 32'd4;
  assign pc_target    = pc_q + dec_i.imm;

  assign exec_ok = (state_q == CTRL_EXECUTE) && !dec_i.illegal;
  assign mem_op  = dec_i.load || dec_i.store;

  assign fetch.req  = fetch_req_q;
  assign fetch.addr = pc_q;

  // Memory request is issued from the execute cycle
  assign lsu.req   = exec_ok && mem_op;
  assign lsu.we    = dec_i.store;
  assign lsu.addr  = alu_result;
  assign lsu.wdata = rf_rdata_b_i;

  // Write-back
  always_comb begin
    rf_we_o    = 1'b0;
    rf_waddr_o = dec_i.rd;
    rf_wdata_o = alu_result;
    if (exec_ok && !mem_op) begin
      rf_we_o = dec_i.reg_write;
      if (dec_i.jump) begin
        rf_wdata_o = pc_plus4;
      end
    end else if ((state_q == CTRL_MEMORY) && lsu.done && !lsu.err) begin
      rf_we_o    = dec_i.load;
      rf_wdata_o = lsu.rdata;
    end
  end

  assign halted_o = (state_q == CTRL_HALTED);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= CTRL_IDLE;
      pc_q        <= '0;
      fetch_req_q <= 1'b0;
    end else begin
      fetch_req_q <= 1'b0;
      case (state_q)
        CTRL_IDLE: begin
          if (fetch_enable_i) begin
            pc_q        <= boot_addr_i;
            fetch_req_q <= 1'b1;
            state_q     <= CTRL_FETCH;
          end
        end
        CTRL_FETCH: begin
          if (fetch.valid) begin
            state_q <= fetch.err ? CTRL_HALTED : CTRL_EXECUTE;
          end
        end
        CTRL_EXECUTE: begin
          if (dec_i.illegal) begin
            state_q <= CTRL_HALTED;
          end else if (mem_op) begin
            state_q <= CTRL_MEMORY;
          end else begin
            pc_q        <= (dec_i.jump || branch_taken) ? pc_target : pc_plus4;
            fetch_req_q <= 1'b1;
            state_q     <= CTRL_FETCH;
          end
        end
        CTRL_MEMORY: begin
          if (lsu.done && lsu.err) begin
            state_q <= CTRL_HALTED;
          end else if (lsu.done) begin
            pc_q        <= pc_plus4;
            fetch_req_q <= 1'b1;
            state_q     <= CTRL_FETCH;
          end
        end
        // Halted until reset
        default: state_q <= CTRL_HALTED;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == CTRL_FETCH) && fetch.valid) begin
      instr_q <= fetch.instr;
    end
  end

endmodule

`default_nettype wire

// File: design/rvs_load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rvs_load_store_unit (
  input  logic           clk_i,
  input  logic           rst_i,
  lsu_if.slave           lsu,
  output logic           data_req_o,
  input  logic           data_gnt_i,
  input  logic           data_rvalid_i,
  output logic           data_we_o,
  output rvs_pkg::addr_t data_addr_o,
  output rvs_pkg::word_t data_wdata_o,
  input  rvs_pkg::word_t data_rdata_i,
  input  logic           data_err_i
);
  import rvs_pkg::*;

  typedef enum logic {
    LS_GNT,
    LS_RVALID
  } ls_state_e;

  ls_state_e state_q;
  logic      pend_q;
  logic      misal_q;
  logic      aligned;
  logic      we_q;
  addr_t     addr_q;
  word_t     wdata_q;

  // Word accesses only
  assign aligned = (lsu.addr[1:0] == 2'b00);

  assign data_req_o   = (state_q == LS_GNT) && ((lsu.req && aligned) || pend_q);
  assign data_we_o    = pend_q ? we_q : lsu.we;
  assign data_addr_o  = pend_q ? addr_q : lsu.addr;
  assign data_wdata_o = pend_q ? wdata_q : lsu.wdata;

  // A misaligned access completes with err and never reaches the bus
  assign lsu.done  = (state_q == LS_RVALID) && (misal_q || data_rvalid_i);
  assign lsu.err   = misal_q || data_err_i;
  assign lsu.rdata = data_rdata_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= LS_GNT;
      pend_q  <= 1'b0;
      misal_q <= 1'b0;
    end else begin
      case (state_q)
        LS_GNT: begin
          if (lsu.req && !aligned) begin
            state_q <= LS_RVALID;
            misal_q <= 1'b1;
          end else if (data_req_o && data_gnt_i) begin
            state_q <= LS_RVALID;
            pend_q  <= 1'b0;
          end else if (data_req_o) begin
            pend_q <= 1'b1;
          end
        end
        default: begin
          if (lsu.done) begin
            state_q <= LS_GNT;
            misal_q <= 1'b0;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (lsu.req) begin
      we_q    <= lsu.we;
      addr_q  <= lsu.addr;
      wdata_q <= lsu.wdata;
    end
  end

endmodule

`default_nettype wire

// File: design/rvs_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module rvs_wrapper #(
  parameter int RF_NUM_REGS = 32
) (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            fetch_enable_i,
  input  rvs_pkg::addr_t  boot_addr_i,

  // Instruction memory bus
  output logic            instr_req_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  output rvs_pkg::addr_t  instr_addr_o,
  input  rvs_pkg::instr_t instr_rdata_i,
  input  logic            instr_err_i,

  // Data memory bus
  output logic            data_req_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  output logic            data_we_o,
  output rvs_pkg::addr_t  data_addr_o,
  output rvs_pkg::word_t  data_wdata_o,
  input  rvs_pkg::word_t  data_rdata_i,
  input  logic            data_err_i,

  output logic            halted_o
);
  import rvs_pkg::*;

  instr_t   instr;
  decoded_t dec;
  reg_idx_t rf_raddr_a;
  reg_idx_t rf_raddr_b;
  word_t    rf_rdata_a;
  word_t    rf_rdata_b;
  logic     rf_we;
  reg_idx_t rf_waddr;
  word_t    rf_wdata;

  fetch_if fetch_bus ();
  lsu_if   lsu_bus ();

  rvs_fetch_unit fetch_unit_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fetch          (fetch_bus),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i)
  );

  rvs_decoder #(
    .RF_NUM_REGS (RF_NUM_REGS)
  ) decoder_i (
    .instr_i (instr),
    .dec_o   (dec)
  );

  rvs_regfile #(
    .RF_NUM_REGS (RF_NUM_REGS)
  ) regfile_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

  rvs_controller controller_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .fetch          (fetch_bus),
    .lsu            (lsu_bus),
    .instr_o        (instr),
    .dec_i          (dec),
    .rf_raddr_a_o   (rf_raddr_a),
    .rf_raddr_b_o   (rf_raddr_b),
    .rf_rdata_a_i   (rf_rdata_a),
    .rf_rdata_b_i   (rf_rdata_b),
    .rf_we_o        (rf_we),
    .rf_waddr_o     (rf_waddr),
    .rf_wdata_o     (rf_wdata),
    .halted_o       (halted_o)
  );

  rvs_load_store_unit load_store_unit_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .lsu           (lsu_bus),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_we_o     (data_we_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .data_rdata_i  (data_rdata_i),
    .data_err_i    (data_err_i)
  );

endmodule

`default_nettype wire

// File: testbench/rvs_tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rvs_tb_checker (
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  input  wire logic        instr_req_o,
  input  wire logic        data_req_o,
  input  wire logic        data_gnt_i,
  input  wire logic        data_we_o,
  input  wire logic [31:0] data_addr_o,
  input  wire logic [31:0] data_wdata_o,
  input  wire logic        halted_o
);

  logic        store_seen;
  logic [31:0] store_val;
  int          req_after_halt;
  int          pass_count;
  int          fail_count;

  initial begin
    store_seen     <= 1'b0;
    store_val      <= '0;
    req_after_halt <= 0;
    pass_count     = 0;
    fail_count     = 0;
  end

  // Result store is the granted write to 0x100
  always @(posedge clk_i) begin
    if (!rst_i && data_req_o && data_gnt_i && data_we_o && (data_addr_o == 32'h100)) begin
      store_seen <= 1'b1;
      store_val  <= data_wdata_o;
    end
    if (halted_o && (instr_req_o || data_req_o)) begin
      req_after_halt <= req_after_halt + 1;
    end
  end

  task automatic clear_test();
    store_seen     <= 1'b0;
    store_val      <= '0;
    req_after_halt <= 0;
  endtask

  task automatic finish_test(input string name, input logic [31:0] exp_val,
                             input logic halt_exp, input logic timed_out);
    logic ok;
    ok = 1'b0;
    if (timed_out) begin
      $display("%s: no store and no halt before the timeout", name);
    end else if (halt_exp && !halted_o) begin
      $display("%s: core did not halt", name);
    end else if (halt_exp && store_seen) begin
      $display("%s: core stored a result although it should halt", name);
    end else if (halt_exp && (req_after_halt != 0)) begin
      $display("%s: bus request issued after halt", name);
    end else if (!halt_exp && halted_o) begin
      $display("%s: core halted unexpectedly", name);
    end else if (!halt_exp && (store_val !== exp_val)) begin
      $display("CHECK FAILED %s expected %08h actual %08h", name, exp_val, store_val);
    end else begin
      ok = 1'b1;
      $display("%s: ok", name);
    end
    if (ok) begin
      pass_count++;
    end else begin
      fail_count++;
    end
  endtask

  task automatic print_counts();
    $display("tests run %0d, passed %0d, failed %0d",
             pass_count + fail_count, pass_count, fail_count);
  endtask

endmodule

`default_nettype wire

// File: testbench/rvs_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module rvs_asserts (
  input wire logic        clk_i,
  input wire logic        rst_i,
  input wire logic        instr_req_o,
  input wire logic        instr_gnt_i,
  input wire logic [31:0] instr_addr_o,
  input wire logic        data_req_o,
  input wire logic        data_gnt_i,
  input wire logic        data_we_o,
  input wire logic [31:0] data_addr_o,
  input wire logic [31:0] data_wdata_o,
  input wire logic        halted_o
);

  // Request and address held until granted
  a_instr_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("instruction request changed before grant");

  a_data_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o) &&
    $stable(data_we_o) && $stable(data_wdata_o))
    else $error("data request changed before grant");

  // Request drops in the cycle after its grant
  a_instr_drop: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_req_o && instr_gnt_i |=> !instr_req_o)
    else $error("instruction request still high after grant");

  a_data_drop: assert property (@(posedge clk_i) disable iff (rst_i)
    data_req_o && data_gnt_i |=> !data_req_o)
    else $error("data request still high after grant");

  a_halt_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    halted_o |-> !instr_req_o && !data_req_o)
    else $error("bus request while halted");

endmodule

bind rvs_wrapper rvs_asserts i_asserts (.*);

`default_nettype wire

// File: testbench/rvs_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rvs_tb_clkgen (
  output logic clk_o
);
  initial clk_o = 1'b0;
  always #20 clk_o = ~clk_o;
endmodule

module rvs_tb;

  localparam int OP_ADD = 0;
  localparam int OP_SUB = 1;
  localparam int OP_AND = 2;
  localparam int OP_OR  = 3;
  localparam int OP_XOR = 4;
  localparam int OP_LDST = 5;
  localparam int OP_BEQ = 6;
  localparam int OP_BNE = 7;
  localparam int OP_X0  = 8;
  localparam int OP_ILL = 9;
  localparam int OP_IERR = 10;

  logic        clk;
  logic        rst_i;
  logic        fetch_enable_i;
  logic [31:0] boot_addr_i;
  logic        instr_req_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_addr_o;
  logic [31:0] instr_rdata_i;
  logic        instr_err_i;
  logic        data_req_o;
  logic        data_gnt_i;
  logic        data_rvalid_i;
  logic        data_we_o;
  logic [31:0] data_addr_o;
  logic [31:0] data_wdata_o;
  logic [31:0] data_rdata_i;
  logic        data_err_i;
  logic        halted_o;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] rng;
  logic [31:0] ierr_addr;
  logic        use_delay;

  // Test table
  string       t_name [$];
  int          t_op [$];
  logic [31:0] t_a [$];
  logic [31:0] t_b [$];
  logic [31:0] t_exp [$];
  logic        t_halt [$];
  logic        t_dly [$];
  logic        t_rnd [$];

  rvs_tb_clkgen i_clk (.clk_o(clk));

  rvs_wrapper #(.RF_NUM_REGS(32)) i_dut (.clk_i(clk), .*);

  rvs_tb_checker i_chk (
    .clk_i(clk), .rst_i(rst_i), .instr_req_o(instr_req_o), .data_req_o(data_req_o),
    .data_gnt_i(data_gnt_i), .data_we_o(data_we_o), .data_addr_o(data_addr_o),
    .data_wdata_o(data_wdata_o), .halted_o(halted_o)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int pick_delay();
    rng = xorshift(rng);
    return use_delay ? int'({30'b0, rng[1:0]}) : 0;
  endfunction

  // Instruction encoders
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_jal_self();
    return {1'b0, 10'd0, 1'b0, 8'd0, 5'd0, 7'b1101111};
  endfunction

  // Expected result from the RV32I rules
  function automatic logic [31:0] model(input int op, input logic [31:0] a,
                                        input logic [31:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_BEQ:  return (a == b) ? 32'd1 : 32'd2;
      OP_BNE:  return (a != b) ? 32'd1 : 32'd2;
      OP_LDST: return a;
      default: return 32'd0;
    endcase
  endfunction

  task automatic add_test(input string name, input int op, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] exp_val,
                          input logic halt, input logic dly, input logic rnd);
    t_name.push_back(name);
    t_op.push_back(op);
    t_a.push_back(a);
    t_b.push_back(b);
    t_exp.push_back(exp_val);
    t_halt.push_back(halt);
    t_dly.push_back(dly);
    t_rnd.push_back(rnd);
  endtask

  task automatic build_program(input int op, input logic [31:0] a, input logic [31:0] b);
    logic [31:0] ha;
    logic [31:0] hb;
    // Unused words are NOPs whose immediate is the word index
    for (int i = 0; i < 256; i++) begin
      imem[i] = enc_i(7'b0010011, 3'b000, 5'd0, 5'd0, 12'(i));
      dmem[i] = 32'h5A5A_0000 ^ 32'(i * 32'h0101_0101);
    end
    ha = (a + 32'h800) >> 12;
    hb = (b + 32'h800) >> 12;
    imem[0] = {ha[19:0], 5'd1, 7'b0110111};
    imem[1] = enc_i(7'b0010011, 3'b000, 5'd1, 5'd1, a[11:0]);
    imem[2] = {hb[19:0], 5'd2, 7'b0110111};
    imem[3] = enc_i(7'b0010011, 3'b000, 5'd2, 5'd2, b[11:0]);
    imem[6] = enc_jal_self();
    case (op)
      OP_ADD:  imem[4] = enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
      OP_SUB:  imem[4] = enc_r(7'h20, 3'b000, 5'd3, 5'd1, 5'd2);
      OP_AND:  imem[4] = enc_r(7'h00, 3'b111, 5'd3, 5'd1, 5'd2);
      OP_OR:   imem[4] = enc_r(7'h00, 3'b110, 5'd3, 5'd1, 5'd2);
      OP_XOR:  imem[4] = enc_r(7'h00, 3'b100, 5'd3, 5'd1, 5'd2);
      OP_ILL:  imem[4] = 32'hFFFF_FFFF;
      OP_X0: begin
        imem[4] = enc_i(7'b0010011, 3'b000, 5'd0, 5'd0, 12'd123);
        imem[5] = enc_sw(5'd0, 12'h100);
      end
      OP_LDST: begin
        imem[4] = enc_sw(5'd1, 12'h200);
        imem[5] = enc_i(7'b0000011, 3'b010, 5'd4, 5'd0, 12'h200);
        imem[6] = enc_sw(5'd4, 12'h100);
        imem[7] = enc_jal_self();
      end
      OP_BEQ, OP_BNE: begin
        // Taken path at 32 stores 1, fall-through stores 2
        imem[4]  = enc_b((op == OP_BEQ) ? 3'b000 : 3'b001, 5'd1, 5'd2, 13'd16);
        imem[5]  = enc_i(7'b0010011, 3'b000, 5'd3, 5'd0, 12'd2);
        imem[6]  = enc_sw(5'd3, 12'h100);
        imem[7]  = enc_jal_self();
        imem[8]  = enc_i(7'b0010011, 3'b000, 5'd3, 5'd0, 12'd1);
        imem[9]  = enc_sw(5'd3, 12'h100);
        imem[10] = enc_jal_self();
      end
      default: ;
    endcase
    if (op <= OP_XOR) begin
      imem[5] = enc_sw(5'd3, 12'h100);
    end
  endtask

  // Memory models for both buses drive their inputs 4 ns after the edge
  int          i_phase;
  int          i_cnt;
  logic [31:0] i_addr;
  int          d_phase;
  int          d_cnt;
  logic [31:0] d_addr;
  logic        d_we;

  always @(posedge clk) begin
    #4;
    if (rst_i) begin
      instr_gnt_i    = 1'b0;
      instr_rvalid_i = 1'b0;
      instr_err_i    = 1'b0;
      data_gnt_i     = 1'b0;
      data_rvalid_i  = 1'b0;
      i_phase        = 0;
      d_phase        = 0;
    end else begin
      if (instr_rvalid_i) begin
        instr_rvalid_i = 1'b0;
        instr_err_i    = 1'b0;
      end
      if (instr_gnt_i) begin
        instr_gnt_i = 1'b0;
        i_phase     = 2;
        i_cnt       = pick_delay();
      end
      if (i_phase == 2) begin
        if (i_cnt == 0) begin
          instr_rvalid_i = 1'b1;
          instr_rdata_i  = imem[i_addr[9:2]];
          instr_err_i    = (i_addr == ierr_addr);
          i_phase        = 0;
        end else begin
          i_cnt--;
        end
      end else if (instr_req_o) begin
        if (i_phase == 0) begin
          i_phase = 1;
          i_cnt   = pick_delay();
        end
        if (i_cnt == 0) begin
          instr_gnt_i = 1'b1;
          i_addr      = instr_addr_o;
        end else begin
          i_cnt--;
        end
      end
      if (data_rvalid_i) begin
        data_rvalid_i = 1'b0;
      end
      if (data_gnt_i) begin
        data_gnt_i = 1'b0;
        d_phase    = 2;
        d_cnt      = pick_delay();
      end
      if (d_phase == 2) begin
        if (d_cnt == 0) begin
          data_rvalid_i = 1'b1;
          data_rdata_i  = d_we ? 32'h0 : dmem[d_addr[9:2]];
          d_phase       = 0;
        end else begin
          d_cnt--;
        end
      end else if (data_req_o) begin
        if (d_phase == 0) begin
          d_phase = 1;
          d_cnt   = pick_delay();
        end
        if (d_cnt == 0) begin
          data_gnt_i = 1'b1;
          d_addr     = data_addr_o;
          d_we       = data_we_o;
          if (data_we_o) begin
            dmem[data_addr_o[9:2]] = data_wdata_o;
          end
        end else begin
          d_cnt--;
        end
      end
    end
  end

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp_val;
    int          cycles;
    logic        timed_out;
    rst_i          = 1'b1;
    fetch_enable_i = 1'b0;
    boot_addr_i    = 32'h0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = 32'h0;
    instr_err_i    = 1'b0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = 32'h0;
    data_err_i     = 1'b0;
    rng            = 32'd72901;
    use_delay      = 1'b0;
    ierr_addr      = 32'hFFFF_FFFF;

    add_test("add_fixed", OP_ADD, 32'h1234_5678, 32'h0FED_CBA8, 32'h2222_2220, 0, 0, 0);
    add_test("sub_fixed", OP_SUB, 32'd5, 32'd7, 32'hFFFF_FFFE, 0, 0, 0);
    add_test("and_fixed", OP_AND, 32'hF0F0_FF00, 32'h0FF0_F0F0, 32'h00F0_F000, 0, 0, 0);
    add_test("or_fixed", OP_OR, 32'hF000_0000, 32'h0000_000F, 32'hF000_000F, 0, 0, 0);
    add_test("xor_fixed", OP_XOR, 32'hAAAA_5555, 32'hFFFF_0000, 32'h5555_5555, 0, 0, 0);
    add_test("add_fixed_dly", OP_ADD, 32'h1234_5678, 32'h0FED_CBA8, 32'h2222_2220, 0, 1, 0);
    add_test("sub_fixed_dly", OP_SUB, 32'd5, 32'd7, 32'hFFFF_FFFE, 0, 1, 0);
    add_test("add_rand", OP_ADD, 0, 0, 0, 0, 1, 1);
    add_test("sub_rand", OP_SUB, 0, 0, 0, 0, 0, 1);
    add_test("and_rand", OP_AND, 0, 0, 0, 0, 1, 1);
    add_test("or_rand", OP_OR, 0, 0, 0, 0, 0, 1);
    add_test("xor_rand", OP_XOR, 0, 0, 0, 0, 1, 1);
    add_test("ldst_rand", OP_LDST, 0, 0, 0, 0, 0, 1);
    add_test("ldst_rand_dly", OP_LDST, 0, 0, 0, 0, 1, 1);
    add_test("beq_taken", OP_BEQ, 32'd77, 32'd77, 32'd1, 0, 0, 0);
    add_test("beq_not_taken", OP_BEQ, 32'd77, 32'd78, 32'd2, 0, 1, 0);
    add_test("bne_taken", OP_BNE, 32'd3, 32'd4, 32'd1, 0, 1, 0);
    add_test("bne_not_taken", OP_BNE, 32'd9, 32'd9, 32'd2, 0, 0, 0);
    add_test("x0_write", OP_X0, 32'd1, 32'd2, 32'd0, 0, 0, 0);
    add_test("illegal_instr", OP_ILL, 32'd1, 32'd2, 32'd0, 1, 0, 0);
    add_test("instr_bus_err", OP_IERR, 32'd1, 32'd2, 32'd0, 1, 1, 0);

    for (int t = 0; t < t_name.size(); t++) begin
      a       = t_a[t];
      b       = t_b[t];
      exp_val = t_exp[t];
      if (t_rnd[t]) begin
        rng     = xorshift(rng);
        a       = rng;
        rng     = xorshift(rng);
        b       = rng;
        exp_val = model(t_op[t], a, b);
      end
      @(posedge clk);
      #2;
      rst_i          = 1'b1;
      fetch_enable_i = 1'b0;
      use_delay      = t_dly[t];
      ierr_addr      = (t_op[t] == OP_IERR) ? 32'h10 : 32'hFFFF_FFFF;
      build_program(t_op[t], a, b);
      i_chk.clear_test();
      repeat (5) @(posedge clk);
      #2;
      rst_i          = 1'b0;
      fetch_enable_i = 1'b1;
      cycles    = 0;
      timed_out = 1'b0;
      while (!i_chk.store_seen && !halted_o && !timed_out) begin
        @(posedge clk);
        #2;
        cycles++;
        timed_out = (cycles >= 500);
      end
      // Quiet window after a halt
      if (halted_o) begin
        repeat (20) @(posedge clk);
        #2;
      end
      i_chk.finish_test(t_name[t], exp_val, t_halt[t], timed_out);
    end

    i_chk.print_counts();
    if (i_chk.fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
design/rvs_pkg.sv
design/rvs_ifs.sv
design/rvs_fetch_unit.sv
design/rvs_decoder.sv
design/rvs_regfile.sv
design/rvs_controller.sv
design/rvs_load_store_unit.sv
design/rvs_wrapper.sv
testbench/rvs_tb_checker.sv
testbench/rvs_asserts.sv
testbench/rvs_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module rvs_tb -Mdir obj_dir -f vlog.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vrvs_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$LOG"; then
  exit 1
fi
exit 0
